// File: rtl/arith_pkg.sv
package arith_pkg;

    // kyber modulus, fits in one 12-bit half
    localparam logic [11:0] kyber_q = 12'd3329;

    // dilithium modulus, 23 bits
    localparam logic [22:0] dil_q = 23'd8380417;

    // coefficient and operand word widths
    localparam int coef_w = 12;
    localparam int word_w = 24;

    // one kyber coefficient
    typedef logic [coef_w-1:0] coef_t;

    // full operand word, also a dilithium coefficient
    typedef logic [word_w-1:0] word_t;

    // word seen as two kyber coefficients, hi in bits 23:12
    typedef struct packed {
        coef_t hi;
        coef_t lo;
    } coef_pair_t;

endpackage

// File: rtl/ctrl_pkg.sv
package ctrl_pkg;

    import arith_pkg::*;

    // operation select for the add/sub unit
    typedef enum logic [1:0] {
        op_bfly2    = 2'b00,
        op_r4_lane0 = 2'b01,
        op_r4_lane1 = 2'b10,
        op_dil_add  = 2'b11
    } op_t;

    // registered command out of the decode stage
    typedef struct packed {
        logic       valid;
        op_t        op;
        coef_pair_t a;
        coef_pair_t b;
        // 1 picks b_hi - a_hi, 0 picks a_lo - b_lo
        logic       hi_sub_swap;
        // both addends from operand a
        logic       kyber_bfly;
    } cmd_t;

    // lane results handed to the pack stage
    typedef struct packed {
        logic  valid;
        op_t   op;
        coef_t add_res;
        coef_t sub_res;
        word_t dil_res;
    } lanes_t;

endpackage

// File: rtl/op_decode.sv
`timescale 1ns/1ps

module op_decode
    import arith_pkg::*, ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  op_t   op,
    input  word_t a,
    input  word_t b,
    output cmd_t  cmd
);

    // lane controls decoded from the op code
    logic bfly_d;
    logic swap_d;

    // control registers
    logic valid_q;
    op_t  op_q;
    logic bfly_q;
    logic swap_q;

    // operand registers
    coef_pair_t a_q;
    coef_pair_t b_q;

    always_comb begin
        bfly_d = 1'b0;
        swap_d = 1'b0;
        case (op)
            // radix-2: hi/lo of operand a into both lanes
            op_bfly2: bfly_d = 1'b1;
            // radix-4 lane 0 subtracts the high halves
            op_r4_lane0: swap_d = 1'b1;
            // lane 1 subtracts low halves, dilithium ignores both
            default: begin
                bfly_d = 1'b0;
                swap_d = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            op_q    <= op_bfly2;
            bfly_q  <= 1'b0;
            swap_q  <= 1'b0;
        end else begin
            valid_q <= in_valid;
            op_q    <= op;
            bfly_q  <= bfly_d;
            swap_q  <= swap_d;
        end
    end

    // operands only load with a valid sample
    always_ff @(posedge clk) begin
        if (in_valid) begin
            a_q <= a;
            b_q <= b;
        end
    end

    assign cmd = '{
        valid:       valid_q,
        op:          op_q,
        a:           a_q,
        b:           b_q,
        hi_sub_swap: swap_q,
        kyber_bfly:  bfly_q
    };

endmodule

// File: rtl/mod_addsub_execute.sv
`timescale 1ns/1ps

module mod_addsub_execute
    import arith_pkg::*, ctrl_pkg::*;
(
    input  cmd_t   cmd,
    output lanes_t lanes
);

    // adder and subtractor operands
    coef_t add_x;
    coef_t add_y;
    coef_t sub_x;
    coef_t sub_y;

    // 12-bit modular add
    logic  add_c;
    coef_t add_s;
    logic  add_b;
    coef_t add_d;
    coef_t add_res;

    // 12-bit modular sub
    logic  sub_b;
    coef_t sub_s;
    coef_t sub_res;

    // 24-bit dilithium add
    logic [12:0] lo_sum;
    logic [12:0] hi_sum;
    logic [24:0] dil_raw;
    logic        dil_b;
    word_t       dil_d;
    logic        dil_ge;
    word_t       dil_res;

    // operand routing per lane controls
    always_comb begin
        if (cmd.kyber_bfly) begin
            // radix-2: hi +/- lo of operand a
            add_x = cmd.a.hi;
            add_y = cmd.a.lo;
            sub_x = cmd.a.hi;
            sub_y = cmd.a.lo;
        end else if (cmd.hi_sub_swap) begin
            // lane 0: a_lo + b_lo, b_hi - a_hi
            add_x = cmd.a.lo;
            add_y = cmd.b.lo;
            sub_x = cmd.b.hi;
            sub_y = cmd.a.hi;
        end else begin
            // lane 1: a_hi + b_hi, a_lo - b_lo
            add_x = cmd.a.hi;
            add_y = cmd.b.hi;
            sub_x = cmd.a.lo;
            sub_y = cmd.b.lo;
        end
    end

    // raw sum with carry out
    assign {add_c, add_s} = {1'b0, add_x} + {1'b0, add_y};

    // trial subtraction of q, borrow means sum < q
    assign {add_b, add_d} = {1'b0, add_s} - {1'b0, kyber_q};

    // take corrected value on carry or when no borrow
    assign add_res = (add_c | ~add_b) ? add_d : add_s;

    // raw difference, borrow flags a negative result
    assign {sub_b, sub_s} = {1'b0, sub_x} - {1'b0, sub_y};

    // wrap back into range with +q, uses this lane's own borrow
    assign sub_res = sub_b ? (sub_s + kyber_q) : sub_s;

    // low half add, carry ripples into the high half
    assign lo_sum = {1'b0, cmd.a.lo} + {1'b0, cmd.b.lo};
    assign hi_sum = {1'b0, cmd.a.hi} + {1'b0, cmd.b.hi} + {12'd0, lo_sum[12]};

    // full 25-bit sum
    assign dil_raw = {hi_sum, lo_sum[11:0]};

    // trial subtraction of the dilithium modulus
    assign {dil_b, dil_d} = {1'b0, dil_raw[23:0]} - {2'b00, dil_q};

    // at or above q once the top bit is set or no borrow
    assign dil_ge  = dil_raw[24] | ~dil_b;
    assign dil_res = dil_ge ? dil_d : dil_raw[23:0];

    assign lanes = '{
        valid:   cmd.valid,
        op:      cmd.op,
        add_res: add_res,
        sub_res: sub_res,
        dil_res: dil_res
    };

endmodule

// File: rtl/result_pack.sv
`timescale 1ns/1ps

module result_pack
    import arith_pkg::*, ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  lanes_t lanes,
    output logic   out_valid,
    output word_t  sum
);

    // output word before the register
    word_t packed_word;

    always_comb begin
        // dilithium result by default
        packed_word = lanes.dil_res;
        case (lanes.op)
            // radix-2 keeps the sum in the high half
            op_bfly2: packed_word = {lanes.add_res, lanes.sub_res};
            // radix-4 lanes put the difference on top
            op_r4_lane0: packed_word = {lanes.sub_res, lanes.add_res};
            op_r4_lane1: packed_word = {lanes.sub_res, lanes.add_res};
            op_dil_add: packed_word = lanes.dil_res;
            default: packed_word = lanes.dil_res;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            sum       <= '0;
        end else begin
            out_valid <= lanes.valid;
            // hold last result through idle cycles
            if (lanes.valid) begin
                sum <= packed_word;
            end
        end
    end

endmodule

// File: rtl/mod_adder.sv
`timescale 1ns/1ps

module mod_adder
    import arith_pkg::*, ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  op_t   op,
    input  word_t a,
    input  word_t b,
    output logic  out_valid,
    output word_t sum
);

    // decode to execute, registered
    cmd_t   cmd;

    // execute to pack, combinational
    lanes_t lanes;

    // stage 1, operand and control register
    op_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .op       (op),
        .a        (a),
        .b        (b),
        .cmd      (cmd)
    );

    // modular add/sub lanes
    mod_addsub_execute u_execute (
        .cmd   (cmd),
        .lanes (lanes)
    );

    // stage 2, pack and output register
    result_pack u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .lanes     (lanes),
        .out_valid (out_valid),
        .sum       (sum)
    );

endmodule

// File: test/tb_mod_adder.sv
`timescale 1ns/1ps

module tb_mod_adder
    import arith_pkg::*, ctrl_pkg::*;
;

    // random test lengths
    localparam int n_rand = 64;
    localparam int n_mix  = 32;

    // reset, edge cases, random runs, mixed stream, drains
    localparam int test_cycles = 32 + 4 * n_rand + 2 * n_mix + 5 * 4;
    localparam int cycle_limit = test_cycles + 200;

    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] lfsr_poly = 32'h8020_0003;

    logic  clk;
    logic  rst_n;
    logic  in_valid;
    op_t   op;
    word_t a;
    word_t b;
    logic  out_valid;
    word_t sum;

    logic [31:0] lfsr = 32'ha31f_ca8c;
    int          cycle_count = 0;
    int          n_word_err = 0;
    int          n_valid_err = 0;

    // scoreboard state
    word_t exp_q[$];
    word_t exp_word;
    word_t last_word = '0;
    logic  v_d1;
    logic  v_d2;
    logic  mon_on = 1'b0;

    mod_adder u_mod_adder (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .sum       (sum)
    );

    always #4 clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? lfsr_poly : 32'h0);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // 12 bits, one conditional reduction gives a value below q
    function automatic coef_t rand_coef();
        logic [31:0] v;
        v = take_bits(12);
        if (v >= 32'd3329) v = v - 32'd3329;
        return v[11:0];
    endfunction

    function automatic word_t rand_word(input op_t o);
        logic [31:0] v;
        if (o == op_dil_add) begin
            v = take_bits(23);
            if (v >= 32'd8380417) v = v - 32'd8380417;
            return v[23:0];
        end
        return {rand_coef(), rand_coef()};
    endfunction

    function automatic op_t rand_op();
        logic [31:0] v;
        v = take_bits(2);
        return op_t'(v[1:0]);
    endfunction

    // reference arithmetic, straight from the modular definitions
    function automatic coef_t kyber_add(input coef_t x, input coef_t y);
        int s;
        s = (int'(x) + int'(y)) % int'(kyber_q);
        return s[11:0];
    endfunction

    function automatic coef_t kyber_sub(input coef_t x, input coef_t y);
        int s;
        s = (int'(x) - int'(y) + int'(kyber_q)) % int'(kyber_q);
        return s[11:0];
    endfunction

    function automatic word_t dil_add(input word_t x, input word_t y);
        longint s;
        s = (longint'(x) + longint'(y)) % longint'(dil_q);
        return s[23:0];
    endfunction

    function automatic word_t expected_sum(input op_t o, input word_t x, input word_t y);
        coef_pair_t pa;
        coef_pair_t pb;
        pa = x;
        pb = y;
        case (o)
            op_bfly2:    return {kyber_add(pa.hi, pa.lo), kyber_sub(pa.hi, pa.lo)};
            op_r4_lane0: return {kyber_sub(pb.hi, pa.hi), kyber_add(pa.lo, pb.lo)};
            op_r4_lane1: return {kyber_sub(pa.lo, pb.lo), kyber_add(pa.hi, pb.hi)};
            default:     return dil_add(x, y);
        endcase
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            n_word_err++;
            $display("CHECK FAILED at time %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            n_valid_err++;
            $display("CHECK FAILED at time %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    // one sample in, expected word queued
    task automatic drive_op(input op_t o, input word_t x, input word_t y);
        @(posedge clk);
        in_valid <= 1'b1;
        op       <= o;
        a        <= x;
        b        <= y;
        exp_q.push_back(expected_sum(o, x, y));
    endtask

    task automatic drive_idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic drive_random(input op_t o);
        word_t x;
        word_t y;
        x = rand_word(o);
        y = rand_word(o);
        drive_op(o, x, y);
    endtask

    // idle until every queued result came out
    task automatic drain_pipeline();
        do begin
            drive_idle();
        end while (exp_q.size() != 0);
    endtask

    // in_valid delayed by two register stages
    always @(posedge clk) begin
        if (!rst_n) begin
            v_d1 <= 1'b0;
            v_d2 <= 1'b0;
        end else begin
            v_d1 <= in_valid;
            v_d2 <= v_d1;
        end
    end

    // sample on the falling edge, away from the driving edge
    always @(negedge clk) begin
        if (mon_on) begin
            check_valid(out_valid, v_d2, "out_valid against in_valid delayed by 2");
            if (v_d2) begin
                exp_word = exp_q.pop_front();
                check_word(sum, exp_word, "sum");
                last_word = exp_word;
            end else begin
                // idle cycle keeps the last result
                check_word(sum, last_word, "sum held while idle");
            end
        end
    end

    task automatic reset_behavior();
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_valid(out_valid, 1'b0, "out_valid during reset");
            check_word(sum, '0, "sum during reset");
        end
        @(posedge clk);
        rst_n  <= 1'b1;
        mon_on = 1'b1;
        // monitor expects zero and no valid right after release
        repeat (4) drive_idle();
    endtask

    task automatic butterfly_radix2();
        drive_op(op_bfly2, 24'h000000, 24'h000000);
        drive_op(op_bfly2, {12'd3328, 12'd3328}, 24'h000000);
        drive_op(op_bfly2, {12'd3328, 12'd0}, 24'h000000);
        drive_op(op_bfly2, {12'd0, 12'd3328}, 24'h000000);
        drive_op(op_bfly2, {12'd1234, 12'd1234}, 24'h000000);
        repeat (n_rand) drive_random(op_bfly2);
        drain_pipeline();
    endtask

    task automatic radix4_lane0();
        drive_op(op_r4_lane0, {12'd3328, 12'd3328}, {12'd0, 12'd3328});
        repeat (n_rand) drive_random(op_r4_lane0);
        drain_pipeline();
    endtask

    task automatic radix4_lane1();
        // a_lo below b_lo, difference must wrap through +q
        drive_op(op_r4_lane1, {12'd100, 12'd5}, {12'd200, 12'd3000});
        drive_op(op_r4_lane1, {12'd3328, 12'd0}, {12'd3328, 12'd3328});
        repeat (n_rand) drive_random(op_r4_lane1);
        drain_pipeline();
    endtask

    task automatic dilithium_add();
        drive_op(op_dil_add, 24'd8380416, 24'd1);
        drive_op(op_dil_add, 24'd8380416, 24'd8380416);
        repeat (n_rand) drive_random(op_dil_add);
        drain_pipeline();
    endtask

    task automatic mixed_stream();
        logic [31:0] gap;
        // all ops interleaved, in_valid high every cycle
        repeat (n_mix) drive_random(rand_op());
        // then random idle cycles between samples
        repeat (n_mix) begin
            gap = take_bits(1);
            if (gap[0]) drive_idle();
            else drive_random(rand_op());
        end
        drain_pipeline();
    endtask

    // hang guard
    initial begin
        wait (cycle_count >= cycle_limit);
        $display("timeout: run exceeded %0d cycles without finishing", cycle_limit);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        op       = op_bfly2;
        a        = '0;
        b        = '0;
        reset_behavior();
        butterfly_radix2();
        radix4_lane0();
        radix4_lane1();
        dilithium_add();
        mixed_stream();
        $display("errors: %0d word, %0d valid", n_word_err, n_valid_err);
        if (n_word_err + n_valid_err == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: all.f
rtl/arith_pkg.sv
rtl/ctrl_pkg.sv
rtl/op_decode.sv
rtl/mod_addsub_execute.sv
rtl/result_pack.sv
rtl/mod_adder.sv
test/tb_mod_adder.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only when the log shows the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps --top-module tb_mod_adder \
    -f all.f -o tb_sim > build.log 2>&1 ||
{ echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "Done: no errors" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
